//--- hdl/dp_pkg.sv
package dp_pkg;

    // **********************************************************
    // Sizes
    // **********************************************************
    localparam int packet_size       = 16;
    localparam int op_width          = 2;
    localparam int task_size         = packet_size - op_width;
    localparam int num_edge_pe       = 4;
    localparam int max_replay_iter   = 4;
    localparam int iter_width        = $clog2(max_replay_iter);
    localparam int fifo_depth        = 4;
    localparam int fifo_ptr_width    = $clog2(fifo_depth);
    localparam int fifo_cnt_width    = $clog2(fifo_depth + 1);
    localparam int station_depth     = 4;
    localparam int station_ptr_width = $clog2(station_depth);
    localparam int station_cnt_width = $clog2(station_depth + 1);

    // Field positions inside a command packet
    localparam int mask_msb     = 13;
    localparam int mask_lsb     = 10;
    localparam int mask_width   = mask_msb - mask_lsb + 1;
    localparam int len_width    = 4;
    localparam int cfg_width    = 4;
    localparam int pe_cnt_width = len_width + 1;

    // **********************************************************
    // Types
    // **********************************************************
    typedef enum logic [op_width-1:0] {
        op_task   = 2'b00,
        op_replay = 2'b01,
        op_num_fv = 2'b10,
        op_wbound = 2'b11
    } dp_opcode_e;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_grant,
        st_wait_drain,
        st_wait_stream,
        st_wait_vertex
    } dec_state_e;

    typedef struct packed {
        logic                   valid;
        logic [packet_size-1:0] packet;
    } com_packet_s;

    // Command without its opcode field
    typedef struct packed {
        logic                 valid;
        logic [task_size-1:0] packet;
    } task_packet_s;

    typedef struct packed {
        logic                   valid;
        logic [packet_size-1:0] packet;
    } mem_packet_s;

endpackage

//--- hdl/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo import dp_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  com_packet_s cmd_in,
    input  logic        fifo_stall,
    output com_packet_s fifo_head,
    output logic        fifo_full
);

    logic [packet_size-1:0]    mem [fifo_depth];
    logic [fifo_ptr_width-1:0] rd_ptr;
    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_cnt_width-1:0] count;
    logic                      do_write;
    logic                      do_pop;

    assign fifo_full = (count == fifo_depth);
    assign do_write  = cmd_in.valid && !fifo_full;

    // The head is popped in the same cycle the decoder consumes it
    assign fifo_head.valid  = (count != '0);
    assign fifo_head.packet = mem[rd_ptr];
    assign do_pop           = fifo_head.valid && !fifo_stall;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= cmd_in.packet;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/packet_decoder.sv
`timescale 1ns/1ps

module packet_decoder import dp_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  com_packet_s            fifo_head,
    input  logic                   station_empty,
    input  logic                   station_space,
    input  logic                   grant,
    input  logic                   bank_busy,
    input  logic [num_edge_pe-1:0] pe_idle,
    input  logic                   stream_end,
    input  logic                   vertex_done,
    input  logic                   cntl_done,
    output logic                   task_complete,
    output task_packet_s           task_out,
    output logic                   req,
    output logic                   fifo_stall,
    output logic                   replay_iter_flag,
    output logic [iter_width-1:0]  replay_iter,
    output logic [cfg_width-1:0]   num_fv,
    output logic [cfg_width-1:0]   weights_boundary,
    output mem_packet_s            mem_pkt
);

    dec_state_e             state;
    dec_state_e             state_nx;
    dp_opcode_e             opcode;
    logic [packet_size-1:0] held_pkt;
    logic [mask_width-1:0]  iter_mask;
    logic                   head_valid;
    logic                   task_enabled;
    logic                   task_dispatch;
    logic                   drained;
    logic                   load_held;
    logic                   load_num_fv;
    logic                   load_wbound;
    logic                   advance_iter;

    // **********************************************************
    // Decode of the FIFO head
    // **********************************************************
    // Heads are only presented to us while idle, since the stall is the state itself
    assign head_valid = fifo_head.valid && (state == st_idle);
    assign opcode     = dp_opcode_e'(fifo_head.packet[packet_size-1 -: op_width]);
    assign iter_mask  = fifo_head.packet[mask_msb:mask_lsb];

    // A task that would overflow the station takes the memory path instead
    assign task_enabled  = iter_mask[replay_iter] && station_space;
    assign task_dispatch = head_valid && (opcode == op_task) && task_enabled;

    assign task_out.valid  = task_dispatch;
    assign task_out.packet = fifo_head.packet[task_size-1:0];

    assign load_num_fv = head_valid && (opcode == op_num_fv);
    assign load_wbound = head_valid && (opcode == op_wbound);
    assign load_held   = head_valid && ((opcode == op_replay) ||
                                        ((opcode == op_task) && !task_enabled));

    // Station empty already folds in a write that is still in flight
    assign drained = !bank_busy && station_empty && (&pe_idle);

    assign fifo_stall       = (state != st_idle);
    assign req              = (state == st_wait_grant);
    assign replay_iter_flag = (state == st_wait_vertex);
    assign task_complete    = cntl_done && (state == st_idle);

    // **********************************************************
    // Replay and deferral FSM
    // **********************************************************
    always_comb begin
        state_nx     = state;
        mem_pkt      = '0;
        advance_iter = 1'b0;
        case (state)
            st_idle: begin
                if (head_valid && (opcode == op_replay)) begin
                    state_nx = st_wait_drain;
                end else if (head_valid && (opcode == op_task) && !task_enabled) begin
                    state_nx = st_wait_grant;
                end
            end
            st_wait_grant: begin
                if (grant) begin
                    mem_pkt.valid  = 1'b1;
                    mem_pkt.packet = held_pkt;
                    state_nx       = st_idle;
                end
            end
            st_wait_drain: begin
                if (drained) begin
                    mem_pkt.valid  = 1'b1;
                    mem_pkt.packet = held_pkt;
                    advance_iter   = 1'b1;
                    state_nx       = st_wait_stream;
                end
            end
            st_wait_stream: begin
                if (stream_end) begin
                    state_nx = st_wait_vertex;
                end
            end
            st_wait_vertex: begin
                if (vertex_done) begin
                    state_nx = st_idle;
                end
            end
            default: state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= st_idle;
            replay_iter      <= '0;
            num_fv           <= '0;
            weights_boundary <= '0;
        end else begin
            state <= state_nx;
            if (advance_iter) begin
                replay_iter <= replay_iter + 1'b1;
            end
            if (load_num_fv) begin
                num_fv <= fifo_head.packet[cfg_width-1:0];
            end
            if (load_wbound) begin
                weights_boundary <= fifo_head.packet[cfg_width-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_held) begin
            held_pkt <= fifo_head.packet;
        end
    end

endmodule

//--- hdl/task_station.sv
`timescale 1ns/1ps

module task_station import dp_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  task_packet_s           task_in,
    input  logic [num_edge_pe-1:0] pe_idle,
    output task_packet_s           pe_task,
    output logic [num_edge_pe-1:0] pe_sel,
    output logic                   station_empty,
    output logic                   station_space
);

    logic [task_size-1:0]         mem [station_depth];
    logic [station_ptr_width-1:0] rd_ptr;
    logic [station_ptr_width-1:0] wr_ptr;
    logic [station_cnt_width-1:0] count;
    logic [num_edge_pe-1:0]       idle_pick;
    logic                         do_write;
    logic                         do_issue;

    // Lowest numbered idle PE wins
    always_comb begin
        idle_pick = '0;
        for (int i = num_edge_pe - 1; i >= 0; i--) begin
            if (pe_idle[i]) begin
                idle_pick    = '0;
                idle_pick[i] = 1'b1;
            end
        end
    end

    assign do_write = task_in.valid && (count != station_depth);
    assign do_issue = (count != '0) && (|pe_idle);

    assign pe_task.valid  = do_issue;
    assign pe_task.packet = mem[rd_ptr];
    assign pe_sel         = do_issue ? idle_pick : '0;

    assign station_space = (count < station_depth);
    assign station_empty = (count == '0) && !task_in.valid;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= task_in.packet;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/edge_pe_array.sv
`timescale 1ns/1ps

module edge_pe_array import dp_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  task_packet_s           pe_task,
    input  logic [num_edge_pe-1:0] pe_sel,
    output logic [num_edge_pe-1:0] pe_idle
);

    logic [pe_cnt_width-1:0] pe_cnt [num_edge_pe];
    logic [len_width-1:0]    task_len;
    logic [pe_cnt_width-1:0] load_val;

    // **********************************************************
    // Busy counters, one per edge PE
    // **********************************************************
    assign task_len = pe_task.packet[len_width-1:0];

    // A zero length task still occupies its PE for one cycle
    assign load_val = {1'b0, task_len} + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_edge_pe; i++) begin
                pe_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_edge_pe; i++) begin
                if (pe_task.valid && pe_sel[i]) begin
                    pe_cnt[i] <= load_val;
                end else if (pe_cnt[i] != '0) begin
                    pe_cnt[i] <= pe_cnt[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_edge_pe; i++) begin
            pe_idle[i] = (pe_cnt[i] == '0);
        end
    end

endmodule

//--- hdl/dp_top.sv
`timescale 1ns/1ps

module dp_top import dp_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  com_packet_s            cmd_in,
    input  logic                   grant,
    input  logic                   bank_busy,
    input  logic                   stream_end,
    input  logic                   vertex_done,
    input  logic                   cntl_done,
    output logic                   fifo_full,
    output logic                   req,
    output mem_packet_s            mem_pkt,
    output logic                   task_complete,
    output logic                   replay_iter_flag,
    output logic [iter_width-1:0]  replay_iter,
    output logic [cfg_width-1:0]   num_fv,
    output logic [cfg_width-1:0]   weights_boundary,
    output logic [num_edge_pe-1:0] pe_idle
);

    com_packet_s            fifo_head;
    logic                   fifo_stall;
    task_packet_s           task_out;
    task_packet_s           pe_task;
    logic [num_edge_pe-1:0] pe_sel;
    logic                   station_empty;
    logic                   station_space;

    cmd_fifo i_cmd_fifo (
        .clk        (clk),
        .reset      (reset),
        .cmd_in     (cmd_in),
        .fifo_stall (fifo_stall),
        .fifo_head  (fifo_head),
        .fifo_full  (fifo_full)
    );

    packet_decoder i_packet_decoder (
        .clk              (clk),
        .reset            (reset),
        .fifo_head        (fifo_head),
        .station_empty    (station_empty),
        .station_space    (station_space),
        .grant            (grant),
        .bank_busy        (bank_busy),
        .pe_idle          (pe_idle),
        .stream_end       (stream_end),
        .vertex_done      (vertex_done),
        .cntl_done        (cntl_done),
        .task_complete    (task_complete),
        .task_out         (task_out),
        .req              (req),
        .fifo_stall       (fifo_stall),
        .replay_iter_flag (replay_iter_flag),
        .replay_iter      (replay_iter),
        .num_fv           (num_fv),
        .weights_boundary (weights_boundary),
        .mem_pkt          (mem_pkt)
    );

    task_station i_task_station (
        .clk           (clk),
        .reset         (reset),
        .task_in       (task_out),
        .pe_idle       (pe_idle),
        .pe_task       (pe_task),
        .pe_sel        (pe_sel),
        .station_empty (station_empty),
        .station_space (station_space)
    );

    edge_pe_array i_edge_pe_array (
        .clk     (clk),
        .reset   (reset),
        .pe_task (pe_task),
        .pe_sel  (pe_sel),
        .pe_idle (pe_idle)
    );

endmodule

//--- dv/dp_assertions.sv
`timescale 1ns/1ps

module dp_assertions import dp_pkg::*; (
    input logic                   clk,
    input logic                   reset,
    input logic                   req,
    input logic                   grant,
    input mem_packet_s            mem_pkt,
    input logic                   bank_busy,
    input logic [num_edge_pe-1:0] pe_idle,
    input logic [iter_width-1:0]  replay_iter,
    input logic                   replay_iter_flag,
    input logic                   vertex_done,
    input logic                   cntl_done,
    input logic                   task_complete
);

    // Failed assertion count
    int fail_count = 0;

    // **********************************************************
    // Deferral handshake
    // **********************************************************
    req_holds: assert property (@(posedge clk) disable iff (reset)
            req && !grant |=> req)
        else begin
            $error("req dropped before grant was seen");
            fail_count++;
        end

    grant_sends_packet: assert property (@(posedge clk) disable iff (reset)
            req && grant |-> mem_pkt.valid)
        else begin
            $error("grant arrived but mem_pkt was not valid");
            fail_count++;
        end

    // One grant gives exactly one memory packet
    grant_ends_request: assert property (@(posedge clk) disable iff (reset)
            req && grant |=> !req && !mem_pkt.valid)
        else begin
            $error("req or mem_pkt persisted after grant");
            fail_count++;
        end

    // **********************************************************
    // Replay sequence
    // **********************************************************
    // A mem_pkt without req can only come from a replay packet
    replay_drained: assert property (@(posedge clk) disable iff (reset)
            mem_pkt.valid && !req |-> (&pe_idle) && !bank_busy)
        else begin
            $error("replay fetch issued while the datapath was busy");
            fail_count++;
        end

    iter_advances: assert property (@(posedge clk) disable iff (reset)
            mem_pkt.valid && !req |=> (replay_iter - $past(replay_iter)) == 2'd1)
        else begin
            $error("replay_iter did not advance by one");
            fail_count++;
        end

    flag_holds: assert property (@(posedge clk) disable iff (reset)
            replay_iter_flag && !vertex_done |=> replay_iter_flag)
        else begin
            $error("replay_iter_flag dropped before vertex_done");
            fail_count++;
        end

    complete_gated: assert property (@(posedge clk) disable iff (reset)
            task_complete |-> cntl_done && !req && !replay_iter_flag)
        else begin
            $error("task_complete raised outside the idle state");
            fail_count++;
        end

endmodule

//--- dv/tb_dp_top.sv
`timescale 1ns/1ps

module tb_dp_top import dp_pkg::*; ();

    logic                   clk;
    logic                   reset;
    com_packet_s            cmd_in;
    logic                   grant, bank_busy, stream_end, vertex_done, cntl_done;
    logic                   fifo_full, req, task_complete, replay_iter_flag;
    mem_packet_s            mem_pkt;
    logic [iter_width-1:0]  replay_iter;
    logic [cfg_width-1:0]   num_fv, weights_boundary;
    logic [num_edge_pe-1:0] pe_idle;

    int                     seed = 27288;
    int                     errors = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    int                     start;
    logic [iter_width-1:0]  exp_iter;
    logic [cfg_width-1:0]   exp_fv, exp_wb;
    logic [mask_width-1:0]  mask;
    logic [len_width-1:0]   len;
    logic [packet_size-1:0] pkt, rpkt;
    logic                   busy_seen;

    dp_top i_dp_top (.*);

    bind dp_top dp_assertions i_dp_assertions (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Five tests at 200 cycles each, plus reset
    initial begin
        #(5 * 200 * 100 + 1000);
        $display("Run timed out before all tests finished");
        $display(">>> FAIL");
        $finish;
    end

    // The host side completion strobe toggles every cycle
    initial begin
        cntl_done = 1'b0;
        forever begin
            @(posedge clk);
            #1 cntl_done = ~cntl_done;
        end
    end

    // **********************************************************
    // Helpers
    // **********************************************************
    task automatic tick(input int n = 1);
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic int error_total();
        return errors + i_dp_top.i_dp_assertions.fail_count;
    endfunction

    task automatic expect_value(input string what, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERR at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_total() > start) begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic send_cmd(input logic [packet_size-1:0] p);
        while (fifo_full) begin
            tick();
        end
        cmd_in.valid  = 1'b1;
        cmd_in.packet = p;
        tick();
        cmd_in = '0;
    endtask

    // Plays the memory side of a deferred task
    task automatic serve_request(input logic [packet_size-1:0] exp_pkt);
        int n = 0;
        while (!req && n < 50) begin
            tick();
            n++;
        end
        if (!req) begin
            $display("No memory request was raised for a deferred task");
            errors++;
        end else begin
            tick(1 + ($random(seed) & 3));
            grant = 1'b1;
            @(negedge clk);
            expect_value("mem_pkt.valid", mem_pkt.valid, 1);
            expect_value("deferred mem_pkt", mem_pkt.packet, exp_pkt);
            tick();
            grant = 1'b0;
        end
    endtask

    // Bank is held busy by the caller, then released here
    task automatic serve_replay(input logic [packet_size-1:0] exp_pkt);
        int n = 0;
        tick(1 + ($random(seed) & 3));
        bank_busy = 1'b0;
        @(negedge clk);
        while (!mem_pkt.valid && n < 50) begin
            @(negedge clk);
            n++;
        end
        expect_value("mem_pkt.valid", mem_pkt.valid, 1);
        expect_value("replay mem_pkt", mem_pkt.packet, exp_pkt);
        tick();
        exp_iter = exp_iter + 1'b1;
        expect_value("replay_iter", replay_iter, exp_iter);
        tick(1 + ($random(seed) & 3));
        stream_end = 1'b1;
        tick();
        stream_end = 1'b0;
        tick(1 + ($random(seed) & 3));
        expect_value("replay_iter_flag", replay_iter_flag, 1);
        vertex_done = 1'b1;
        tick();
        vertex_done = 1'b0;
        expect_value("replay_iter_flag", replay_iter_flag, 0);
    endtask

    // **********************************************************
    // Tests
    // **********************************************************
    initial begin
        cmd_in      = '0;
        grant       = 1'b0;
        bank_busy   = 1'b0;
        stream_end  = 1'b0;
        vertex_done = 1'b0;
        exp_iter    = '0;
        reset       = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        start  = error_total();
        exp_fv = cfg_width'($random(seed));
        exp_wb = cfg_width'($random(seed));
        send_cmd({op_num_fv, 10'd0, exp_fv});
        send_cmd({op_wbound, 10'd0, exp_wb});
        tick(4);
        expect_value("num_fv", num_fv, exp_fv);
        expect_value("weights_boundary", weights_boundary, exp_wb);
        finish_test("config");

        start = error_total();
        mask  = mask_width'($random(seed));
        len   = len_width'($random(seed));
        mask[exp_iter] = 1'b0;
        pkt = {op_task, mask, 6'd0, len};
        send_cmd(pkt);
        serve_request(pkt);
        finish_test("deferral");

        start     = error_total();
        busy_seen = 1'b0;
        mask      = mask_width'($random(seed));
        len       = len_width'($random(seed));
        mask[exp_iter] = 1'b1;
        send_cmd({op_task, mask, 6'd0, len});
        repeat (6) begin
            @(negedge clk);
            expect_value("req", req, 0);
            expect_value("mem_pkt.valid", mem_pkt.valid, 0);
            expect_value("task_complete", task_complete, cntl_done);
            if (pe_idle != '1) begin
                busy_seen = 1'b1;
            end
        end
        if (!busy_seen) begin
            $display("No edge PE became busy for an enabled task");
            errors++;
        end
        tick();
        finish_test("enabled");

        // A long task keeps a PE busy while the replay waits to drain
        start     = error_total();
        bank_busy = 1'b1;
        rpkt      = {op_replay, 14'($random(seed))};
        send_cmd({op_task, 4'hf, 6'd0, 4'hf});
        send_cmd(rpkt);
        serve_replay(rpkt);
        finish_test("replay");

        // Two num_fv packets in a row show that the send order is kept
        start     = error_total();
        bank_busy = 1'b1;
        rpkt      = {op_replay, 14'($random(seed))};
        exp_fv    = cfg_width'($random(seed));
        exp_wb    = cfg_width'($random(seed));
        mask      = mask_width'($random(seed));
        len       = len_width'($random(seed));
        mask[exp_iter + 1'b1] = 1'b0;
        pkt = {op_task, mask, 6'd0, len};
        send_cmd(rpkt);
        send_cmd({op_num_fv, 10'd0, ~exp_fv});
        send_cmd({op_num_fv, 10'd0, exp_fv});
        send_cmd({op_wbound, 10'd0, exp_wb});
        send_cmd(pkt);
        expect_value("fifo_full", fifo_full, 1);
        serve_replay(rpkt);
        serve_request(pkt);
        expect_value("num_fv", num_fv, exp_fv);
        expect_value("weights_boundary", weights_boundary, exp_wb);
        finish_test("stall");

        tick(3);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_total());
        if (error_total() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
hdl/dp_pkg.sv
hdl/cmd_fifo.sv
hdl/packet_decoder.sv
hdl/task_station.sv
hdl/edge_pe_array.sv
hdl/dp_top.sv
dv/dp_assertions.sv
dv/tb_dp_top.sv

//--- Makefile
TOP = tb_dp_top
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
